// File: hw/cnn_pkg.sv
`default_nettype none

package cnn_pkg;

  // datapath widths
  localparam int DWIDTH   = 16;
  localparam int ACCWIDTH = 40;
  localparam int LWIDTH   = 8;
  localparam int IMGSIZE  = 12;
  localparam int NETSIZE  = 11;

  typedef logic signed [DWIDTH-1:0]   pix_t;
  typedef logic signed [ACCWIDTH-1:0] acc_t;

  // one layer command, latched by the control core
  typedef struct packed {
    logic [LWIDTH-1:0]  total_in;
    logic [LWIDTH-1:0]  total_out;
    logic [LWIDTH-1:0]  img_size;
    logic [LWIDTH-1:0]  conv_size;
    logic [LWIDTH-1:0]  conv_pad;
    logic [IMGSIZE-1:0] in_offset;
    logic [IMGSIZE-1:0] out_offset;
    logic [NETSIZE-1:0] net_offset;
    logic               bias_en;
    logic               relu_en;
  } layer_cfg_t;

  // one kernel tap on its way to the PE
  typedef struct packed {
    logic [IMGSIZE-1:0] img_addr;
    logic [NETSIZE-1:0] net_addr;
    logic               pad;
    logic               first;
    logic               last;
  } tap_t;

  // sel 0 targets the image store, 1 the network store
  typedef struct packed {
    logic               sel;
    logic [IMGSIZE-1:0] addr;
    pix_t               wdata;
  } host_wr_t;

  typedef struct packed {
    logic [IMGSIZE-1:0] addr;
  } host_rd_t;

endpackage

`default_nettype wire

// File: hw/sync_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sync_ram #(
  parameter type word_t = logic [15:0],
  parameter int  DEPTH  = 256
) (
  input  logic                     clk,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] waddr,
  input  word_t                    wdata,
  input  logic [$clog2(DEPTH)-1:0] raddr,
  output word_t                    rdata
);

  word_t mem [DEPTH];

  // read before write on a shared address
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

// File: hw/conv_tap_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module conv_tap_sequencer #(
  parameter int FSIZE = 5
) (
  input  logic                       clk,
  input  logic                       xrst,
  input  logic                       pass_start,
  input  cnn_pkg::layer_cfg_t        cfg,
  input  logic [cnn_pkg::LWIDTH-1:0] fea_size,
  input  logic [cnn_pkg::LWIDTH-1:0] out_ch,
  output cnn_pkg::tap_t              tap,
  output logic                       tap_valid,
  output logic                       pass_end
);

  localparam int KW = $clog2(FSIZE + 1);
  localparam int CW = cnn_pkg::LWIDTH + 2;

  logic                        busy;
  logic [cnn_pkg::LWIDTH-1:0]  oy;
  logic [cnn_pkg::LWIDTH-1:0]  ox;
  logic [cnn_pkg::LWIDTH-1:0]  ci;
  logic [KW-1:0]               ky;
  logic [KW-1:0]               kx;
  logic                        last_kx;
  logic                        last_ky;
  logic                        last_ci;
  logic                        last_ox;
  logic                        last_oy;
  logic signed [CW-1:0]        iy;
  logic signed [CW-1:0]        ix;
  logic signed [CW-1:0]        img_lim;
  logic [cnn_pkg::IMGSIZE-1:0] img_sq;
  logic [cnn_pkg::NETSIZE-1:0] ksq;
  logic [cnn_pkg::NETSIZE-1:0] block;

  assign last_kx = cnn_pkg::LWIDTH'(kx) == cfg.conv_size - 1'b1;
  assign last_ky = cnn_pkg::LWIDTH'(ky) == cfg.conv_size - 1'b1;
  assign last_ci = ci == cfg.total_in - 1'b1;
  assign last_ox = ox == fea_size - 1'b1;
  assign last_oy = oy == fea_size - 1'b1;

  // input coordinates, negative inside the top/left padding
  assign iy      = signed'(CW'(oy)) + signed'(CW'(ky)) - signed'(CW'(cfg.conv_pad));
  assign ix      = signed'(CW'(ox)) + signed'(CW'(kx)) - signed'(CW'(cfg.conv_pad));
  assign img_lim = signed'(CW'(cfg.img_size));

  assign img_sq = cnn_pkg::IMGSIZE'(cfg.img_size) * cnn_pkg::IMGSIZE'(cfg.img_size);
  assign ksq    = cnn_pkg::NETSIZE'(cfg.conv_size) * cnn_pkg::NETSIZE'(cfg.conv_size);
  assign block  = cnn_pkg::NETSIZE'(cfg.total_in) * ksq + 1'b1;

  assign tap_valid = busy;
  assign pass_end  = busy && last_kx && last_ky && last_ci && last_ox && last_oy;

  always_comb begin
    tap.pad      = iy < 0 || ix < 0 || iy >= img_lim || ix >= img_lim;
    tap.first    = ci == '0 && ky == '0 && kx == '0;
    tap.last     = last_kx && last_ky && last_ci;
    tap.img_addr = cfg.in_offset + cnn_pkg::IMGSIZE'(ci) * img_sq
                 + cnn_pkg::IMGSIZE'(iy) * cnn_pkg::IMGSIZE'(cfg.img_size)
                 + cnn_pkg::IMGSIZE'(ix);
    tap.net_addr = cfg.net_offset + cnn_pkg::NETSIZE'(out_ch) * block
                 + cnn_pkg::NETSIZE'(ci) * ksq
                 + cnn_pkg::NETSIZE'(ky) * cnn_pkg::NETSIZE'(cfg.conv_size)
                 + cnn_pkg::NETSIZE'(kx);
  end

  // kx fastest, then ky, input channel, ox, oy
  always_ff @(posedge clk) begin
    if (!xrst) begin
      busy <= 1'b0;
      oy   <= '0;
      ox   <= '0;
      ci   <= '0;
      ky   <= '0;
      kx   <= '0;
    end else if (pass_start) begin
      busy <= 1'b1;
      oy   <= '0;
      ox   <= '0;
      ci   <= '0;
      ky   <= '0;
      kx   <= '0;
    end else if (busy) begin
      if (pass_end) begin
        busy <= 1'b0;
      end
      if (!last_kx) begin
        kx <= kx + 1'b1;
      end else begin
        kx <= '0;
        if (!last_ky) begin
          ky <= ky + 1'b1;
        end else begin
          ky <= '0;
          if (!last_ci) begin
            ci <= ci + 1'b1;
          end else begin
            ci <= '0;
            if (!last_ox) begin
              ox <= ox + 1'b1;
            end else begin
              ox <= '0;
              oy <= last_oy ? '0 : oy + 1'b1;
            end
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/conv_pe.sv
`timescale 1ns/1ps
`default_nettype none

module conv_pe (
  input  logic          clk,
  input  logic          xrst,
  input  logic          tap_valid,
  input  cnn_pkg::tap_t tap,
  input  cnn_pkg::pix_t pix,
  input  cnn_pkg::pix_t weight,
  input  logic          bias_load,
  input  cnn_pkg::pix_t bias,
  input  logic          bias_en,
  input  logic          relu_en,
  output logic          res_valid,
  output cnn_pkg::pix_t res
);

  localparam cnn_pkg::acc_t SAT_MAX = cnn_pkg::acc_t'((2 ** (cnn_pkg::DWIDTH - 1)) - 1);
  localparam cnn_pkg::acc_t SAT_MIN = -SAT_MAX - 1;

  cnn_pkg::pix_t                     bias_q;
  cnn_pkg::acc_t                     acc;
  cnn_pkg::acc_t                     base;
  cnn_pkg::acc_t                     prod;
  cnn_pkg::acc_t                     acc_next;
  cnn_pkg::acc_t                     clip;
  logic signed [2*cnn_pkg::DWIDTH-1:0] mult;

  assign mult = pix * weight;

  always_comb begin
    base = acc;
    if (tap.first) begin
      base = bias_en ? cnn_pkg::acc_t'(bias_q) : '0;
    end
    // padding taps contribute nothing
    prod     = tap.pad ? '0 : cnn_pkg::acc_t'(mult);
    acc_next = base + prod;
    clip     = (relu_en && acc_next < 0) ? '0 : acc_next;
  end

  always_ff @(posedge clk) begin
    if (bias_load) begin
      bias_q <= bias;
    end
  end

  // accumulator and result word
  always_ff @(posedge clk) begin
    if (tap_valid) begin
      acc <= acc_next;
    end
    if (tap_valid && tap.last) begin
      if (clip > SAT_MAX) begin
        res <= cnn_pkg::pix_t'(SAT_MAX);
      end else if (clip < SAT_MIN) begin
        res <= cnn_pkg::pix_t'(SAT_MIN);
      end else begin
        res <= cnn_pkg::pix_t'(clip);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= tap_valid && tap.last;
    end
  end

endmodule

`default_nettype wire

// File: hw/conv_ctrl_core.sv
`timescale 1ns/1ps
`default_nettype none

module conv_ctrl_core #(
  parameter int FSIZE = 5
) (
  input  logic                        clk,
  input  logic                        xrst,
  input  cnn_pkg::layer_cfg_t         cmd,
  input  logic                        cmd_valid,
  output logic                        cmd_ready,
  output logic                        done,
  input  logic                        host_we,
  input  cnn_pkg::host_wr_t           host_wr,
  input  cnn_pkg::host_rd_t           host_rd,
  output cnn_pkg::pix_t               host_rdata,
  input  cnn_pkg::pix_t               img_rdata,
  output logic                        img_we,
  output logic [cnn_pkg::IMGSIZE-1:0] img_waddr,
  output logic [cnn_pkg::IMGSIZE-1:0] img_raddr,
  output cnn_pkg::pix_t               img_wdata,
  output logic                        net_we,
  output logic [cnn_pkg::NETSIZE-1:0] net_waddr,
  output logic [cnn_pkg::NETSIZE-1:0] net_raddr,
  output cnn_pkg::pix_t               net_wdata,
  output logic                        pass_start,
  input  logic                        pass_end,
  output logic [cnn_pkg::LWIDTH-1:0]  fea_size,
  output logic [cnn_pkg::LWIDTH-1:0]  out_ch,
  output cnn_pkg::layer_cfg_t         cfg_q,
  input  cnn_pkg::tap_t               tap_in,
  input  logic                        tap_valid_in,
  output cnn_pkg::tap_t               tap_q,
  output logic                        tap_valid_q,
  output logic                        bias_load,
  input  logic                        res_valid,
  input  cnn_pkg::pix_t               res
);

  typedef enum logic [1:0] {
    S_WAIT, S_BIAS, S_ACC
  } state_t;

  state_t                      state;
  logic                        idle;
  logic                        accept;
  logic [cnn_pkg::LWIDTH-1:0]  cmd_k;
  cnn_pkg::layer_cfg_t         cmd_fix;
  logic [cnn_pkg::NETSIZE-1:0] ksq;
  logic [cnn_pkg::NETSIZE-1:0] block;
  logic [cnn_pkg::NETSIZE-1:0] bias_addr;
  logic [cnn_pkg::IMGSIZE-1:0] fea_sq;
  logic [cnn_pkg::IMGSIZE-1:0] res_cnt;
  logic [cnn_pkg::IMGSIZE-1:0] out_addr;
  logic                        taps_done;
  logic                        chan_end;
  logic                        layer_end;

  // =========================================================================
  // layer state machine
  // =========================================================================

  assign idle      = state == S_WAIT;
  assign cmd_ready = idle;
  assign accept    = cmd_valid && cmd_ready;
  assign chan_end  = state == S_ACC && res_valid && taps_done && res_cnt == fea_sq - 1'b1;
  assign layer_end = out_ch == cfg_q.total_out - 1'b1;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state  <= S_WAIT;
      out_ch <= '0;
      done   <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        S_WAIT: begin
          if (accept) begin
            state  <= S_BIAS;
            out_ch <= '0;
          end
        end
        S_BIAS: begin
          state <= S_ACC;
        end
        S_ACC: begin
          if (chan_end && layer_end) begin
            state <= S_WAIT;
            done  <= 1'b1;
          end else if (chan_end) begin
            state  <= S_BIAS;
            out_ch <= out_ch + 1'b1;
          end
        end
        default: begin
          state <= S_WAIT;
        end
      endcase
    end
  end

  // =========================================================================
  // configuration latch
  // =========================================================================

  // kernel side capped at the built window size
  assign cmd_k = (cmd.conv_size > cnn_pkg::LWIDTH'(FSIZE)) ? cnn_pkg::LWIDTH'(FSIZE)
                                                           : cmd.conv_size;

  always_comb begin
    cmd_fix           = cmd;
    cmd_fix.conv_size = cmd_k;
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      cfg_q    <= '0;
      fea_size <= '0;
    end else if (accept) begin
      cfg_q    <= cmd_fix;
      fea_size <= cmd.img_size + cmd.conv_pad + cmd.conv_pad - cmd_k + 1'b1;
    end
  end

  assign ksq       = cnn_pkg::NETSIZE'(cfg_q.conv_size) * cnn_pkg::NETSIZE'(cfg_q.conv_size);
  assign block     = cnn_pkg::NETSIZE'(cfg_q.total_in) * ksq + 1'b1;
  assign bias_addr = cfg_q.net_offset + cnn_pkg::NETSIZE'(out_ch) * block
                   + cnn_pkg::NETSIZE'(cfg_q.total_in) * ksq;
  assign fea_sq    = cnn_pkg::IMGSIZE'(fea_size) * cnn_pkg::IMGSIZE'(fea_size);

  // =========================================================================
  // pass control and result write-back
  // =========================================================================

  assign pass_start = state == S_BIAS;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      bias_load   <= 1'b0;
      tap_valid_q <= 1'b0;
      taps_done   <= 1'b0;
      res_cnt     <= '0;
    end else begin
      // bias word is on net_rdata one cycle after the read
      bias_load   <= state == S_BIAS;
      tap_valid_q <= tap_valid_in;
      if (pass_start) begin
        taps_done <= 1'b0;
      end else if (pass_end) begin
        taps_done <= 1'b1;
      end
      if (pass_start) begin
        res_cnt <= '0;
      end else if (res_valid) begin
        res_cnt <= res_cnt + 1'b1;
      end
    end
  end

  // aligns the tap with the memory read data
  always_ff @(posedge clk) begin
    tap_q <= tap_in;
  end

  // output channels are contiguous, so one running address covers the layer
  always_ff @(posedge clk) begin
    if (accept) begin
      out_addr <= cmd.out_offset;
    end else if (!idle && res_valid) begin
      out_addr <= out_addr + 1'b1;
    end
  end

  // host owns the memories only while idle
  assign img_we     = idle ? (host_we && !host_wr.sel) : res_valid;
  assign img_waddr  = idle ? host_wr.addr : out_addr;
  assign img_wdata  = idle ? host_wr.wdata : res;
  assign img_raddr  = idle ? host_rd.addr : tap_in.img_addr;
  assign host_rdata = img_rdata;

  assign net_we    = idle && host_we && host_wr.sel;
  assign net_waddr = host_wr.addr[cnn_pkg::NETSIZE-1:0];
  assign net_wdata = host_wr.wdata;
  assign net_raddr = (state == S_BIAS) ? bias_addr : tap_in.net_addr;

endmodule

`default_nettype wire

// File: hw/conv_layer_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv_layer_top #(
  parameter int FSIZE     = 5,
  parameter int IMG_DEPTH = 4096,
  parameter int NET_DEPTH = 2048
) (
  input  logic                clk,
  input  logic                xrst,
  input  cnn_pkg::layer_cfg_t cmd,
  input  logic                cmd_valid,
  output logic                cmd_ready,
  output logic                done,
  input  logic                host_we,
  input  cnn_pkg::host_wr_t   host_wr,
  input  cnn_pkg::host_rd_t   host_rd,
  output cnn_pkg::pix_t       host_rdata
);

  cnn_pkg::layer_cfg_t         cfg_q;
  logic [cnn_pkg::LWIDTH-1:0]  fea_size;
  logic [cnn_pkg::LWIDTH-1:0]  out_ch;
  logic                        pass_start;
  logic                        pass_end;
  cnn_pkg::tap_t               tap;
  logic                        tap_valid;
  cnn_pkg::tap_t               tap_q;
  logic                        tap_valid_q;
  logic                        bias_load;
  logic                        res_valid;
  cnn_pkg::pix_t               res;
  logic                        img_we;
  logic [cnn_pkg::IMGSIZE-1:0] img_waddr;
  logic [cnn_pkg::IMGSIZE-1:0] img_raddr;
  cnn_pkg::pix_t               img_wdata;
  cnn_pkg::pix_t               img_rdata;
  logic                        net_we;
  logic [cnn_pkg::NETSIZE-1:0] net_waddr;
  logic [cnn_pkg::NETSIZE-1:0] net_raddr;
  cnn_pkg::pix_t               net_wdata;
  cnn_pkg::pix_t               net_rdata;

  conv_ctrl_core #(.FSIZE(FSIZE)) u_core (
    .clk, .xrst, .cmd, .cmd_valid, .cmd_ready, .done,
    .host_we, .host_wr, .host_rd, .host_rdata,
    .img_rdata, .img_we, .img_waddr, .img_raddr, .img_wdata,
    .net_we, .net_waddr, .net_raddr, .net_wdata,
    .pass_start, .pass_end, .fea_size, .out_ch, .cfg_q,
    .tap_in(tap), .tap_valid_in(tap_valid), .tap_q, .tap_valid_q,
    .bias_load, .res_valid, .res
  );

  conv_tap_sequencer #(.FSIZE(FSIZE)) u_seq (
    .clk, .xrst, .pass_start, .cfg(cfg_q), .fea_size, .out_ch,
    .tap, .tap_valid, .pass_end
  );

  // network read data serves as weight and, after a bias read, as bias
  conv_pe u_pe (
    .clk, .xrst, .tap_valid(tap_valid_q), .tap(tap_q),
    .pix(img_rdata), .weight(net_rdata), .bias_load, .bias(net_rdata),
    .bias_en(cfg_q.bias_en), .relu_en(cfg_q.relu_en), .res_valid, .res
  );

  sync_ram #(.word_t(cnn_pkg::pix_t), .DEPTH(IMG_DEPTH)) u_img_ram (
    .clk, .we(img_we), .waddr(img_waddr), .wdata(img_wdata),
    .raddr(img_raddr), .rdata(img_rdata)
  );

  sync_ram #(.word_t(cnn_pkg::pix_t), .DEPTH(NET_DEPTH)) u_net_ram (
    .clk, .we(net_we), .waddr(net_waddr), .wdata(net_wdata),
    .raddr(net_raddr), .rdata(net_rdata)
  );

endmodule

`default_nettype wire

// File: verif/conv_layer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module conv_layer_tb;

  localparam int FSIZE     = 5;
  localparam int IMG_DEPTH = 4096;
  localparam int NET_DEPTH = 2048;

  logic                clk = 1'b0;
  logic                xrst;
  cnn_pkg::layer_cfg_t cmd;
  logic                cmd_valid;
  logic                cmd_ready;
  logic                done;
  logic                host_we;
  cnn_pkg::host_wr_t   host_wr;
  cnn_pkg::host_rd_t   host_rd;
  cnn_pkg::pix_t       host_rdata;

  // shadows of both memories, kept in step with every honored write
  cnn_pkg::pix_t img_sh [IMG_DEPTH];
  cnn_pkg::pix_t net_sh [NET_DEPTH];

  int cycle_cnt    = 0;
  int cycle_limit  = 20;
  int errors       = 0;
  int checks       = 0;
  int tests_run    = 0;
  int tests_failed = 0;

  conv_layer_top #(.FSIZE(FSIZE), .IMG_DEPTH(IMG_DEPTH), .NET_DEPTH(NET_DEPTH)) uut (
    .clk, .xrst, .cmd, .cmd_valid, .cmd_ready, .done,
    .host_we, .host_wr, .host_rd, .host_rdata
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // limit grows with each access and each layer the tests start
  initial begin
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
    end
    $display("run stopped after %0d cycles: tests did not finish in time (%0d errors so far)",
             cycle_cnt, errors);
    $display("STATUS: FAIL");
    $finish;
  end

  // ==========================================================================
  // helpers
  // ==========================================================================

  task automatic add_budget(input int cycles);
    cycle_limit += 2 * cycles;
  endtask

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'($urandom % (hi - lo + 1));
  endfunction

  function automatic cnn_pkg::pix_t img_fill(input int a);
    return cnn_pkg::pix_t'(a * 13) ^ 16'h5a00;
  endfunction

  function automatic cnn_pkg::pix_t net_fill(input int a);
    return cnn_pkg::pix_t'(a * 29) ^ 16'h00c3;
  endfunction

  function automatic cnn_pkg::layer_cfg_t make_cfg(input int tin, input int tout,
      input int img, input int k, input int pad, input int in_off, input int out_off,
      input int net_off, input int bias_en, input int relu_en);
    cnn_pkg::layer_cfg_t c;
    c.total_in   = cnn_pkg::LWIDTH'(tin);
    c.total_out  = cnn_pkg::LWIDTH'(tout);
    c.img_size   = cnn_pkg::LWIDTH'(img);
    c.conv_size  = cnn_pkg::LWIDTH'(k);
    c.conv_pad   = cnn_pkg::LWIDTH'(pad);
    c.in_offset  = cnn_pkg::IMGSIZE'(in_off);
    c.out_offset = cnn_pkg::IMGSIZE'(out_off);
    c.net_offset = cnn_pkg::NETSIZE'(net_off);
    c.bias_en    = bias_en != 0;
    c.relu_en    = relu_en != 0;
    return c;
  endfunction

  function automatic int fea_of(input cnn_pkg::layer_cfg_t c);
    return int'(c.img_size) + 2 * int'(c.conv_pad) - int'(c.conv_size) + 1;
  endfunction

  // taps per channel plus bias read and pipeline overhead
  function automatic int layer_bound(input cnn_pkg::layer_cfg_t c);
    int fea;
    int k;
    fea = fea_of(c);
    k   = int'(c.conv_size);
    return int'(c.total_out) * (fea * fea * int'(c.total_in) * k * k + 8) + 10;
  endfunction

  task automatic check_word(input string name, input int addr, input cnn_pkg::pix_t got,
      input cnn_pkg::pix_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s @0x%03h: got 0x%04h, expected 0x%04h", name, addr, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic end_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("[%0t] %s: ok", $time, name);
    end else begin
      tests_failed++;
      $display("[%0t] %s: failed with %0d errors", $time, name, errors - err_before);
    end
  endtask

  // ==========================================================================
  // host access and layer commands
  // ==========================================================================

  task automatic drive_write(input logic sel, input int addr, input cnn_pkg::pix_t data);
    add_budget(1);
    host_we       = 1'b1;
    host_wr.sel   = sel;
    host_wr.addr  = cnn_pkg::IMGSIZE'(addr);
    host_wr.wdata = data;
    @(posedge clk);
    #1;
    host_we = 1'b0;
  endtask

  task automatic write_img(input int addr, input cnn_pkg::pix_t data);
    drive_write(1'b0, addr, data);
    img_sh[addr] = data;
  endtask

  task automatic write_net(input int addr, input cnn_pkg::pix_t data);
    drive_write(1'b1, addr, data);
    net_sh[addr] = data;
  endtask

  // read data is registered, so it is sampled one edge later
  task automatic host_read(input int addr, output cnn_pkg::pix_t data);
    add_budget(1);
    host_rd.addr = cnn_pkg::IMGSIZE'(addr);
    @(posedge clk);
    #1;
    data = host_rdata;
  endtask

  task automatic send_cmd(input cnn_pkg::layer_cfg_t c);
    logic ready_seen;
    int   waited;
    ready_seen = 1'b0;
    waited     = 0;
    add_budget(20);
    cmd       = c;
    cmd_valid = 1'b1;
    while (!ready_seen && waited < 20) begin
      ready_seen = cmd_ready;
      @(posedge clk);
      #1;
      waited++;
    end
    cmd_valid = 1'b0;
    if (!ready_seen) begin
      report_error("layer command was not accepted within 20 cycles");
    end
  endtask

  task automatic wait_done(input int bound);
    int waited;
    waited = 0;
    add_budget(bound);
    while (done !== 1'b1 && waited < bound) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (done !== 1'b1) begin
      report_error($sformatf("done did not arrive within %0d cycles", bound));
    end
  endtask

  task automatic run_layer(input cnn_pkg::layer_cfg_t c);
    send_cmd(c);
    wait_done(layer_bound(c));
  endtask

  task automatic load_random_layer(input cnn_pkg::layer_cfg_t c, input int p_lo,
      input int p_hi, input int w_lo, input int w_hi, input int b_lo, input int b_hi);
    int n_in;
    int kk;
    int blk;
    int wbase;
    n_in = int'(c.total_in) * int'(c.img_size) * int'(c.img_size);
    kk   = int'(c.conv_size) * int'(c.conv_size);
    blk  = int'(c.total_in) * kk + 1;
    for (int i = 0; i < n_in; i++) begin
      write_img(int'(c.in_offset) + i, cnn_pkg::pix_t'(rand_range(p_lo, p_hi)));
    end
    for (int o = 0; o < int'(c.total_out); o++) begin
      wbase = int'(c.net_offset) + o * blk;
      for (int j = 0; j < blk - 1; j++) begin
        write_net(wbase + j, cnn_pkg::pix_t'(rand_range(w_lo, w_hi)));
      end
      write_net(wbase + blk - 1, cnn_pkg::pix_t'(rand_range(b_lo, b_hi)));
    end
  endtask

  // ==========================================================================
  // reference model
  // ==========================================================================

  function automatic cnn_pkg::pix_t model_pixel(input cnn_pkg::layer_cfg_t c, input int o,
      input int y, input int x);
    int     img;
    int     k;
    int     pad;
    int     wbase;
    int     iy;
    int     ix;
    longint acc;
    img   = int'(c.img_size);
    k     = int'(c.conv_size);
    pad   = int'(c.conv_pad);
    wbase = int'(c.net_offset) + o * (int'(c.total_in) * k * k + 1);
    acc   = 0;
    if (c.bias_en) begin
      acc = longint'(net_sh[wbase + int'(c.total_in) * k * k]);
    end
    for (int i = 0; i < int'(c.total_in); i++) begin
      for (int ky = 0; ky < k; ky++) begin
        for (int kx = 0; kx < k; kx++) begin
          iy = y + ky - pad;
          ix = x + kx - pad;
          // outside the image counts as zero
          if (iy >= 0 && iy < img && ix >= 0 && ix < img) begin
            acc += longint'(img_sh[int'(c.in_offset) + i * img * img + iy * img + ix])
                 * longint'(net_sh[wbase + i * k * k + ky * k + kx]);
          end
        end
      end
    end
    if (c.relu_en && acc < 0) begin
      acc = 0;
    end
    if (acc > 32767) begin
      acc = 32767;
    end else if (acc < -32768) begin
      acc = -32768;
    end
    return cnn_pkg::pix_t'(acc);
  endfunction

  task automatic check_layer(input cnn_pkg::layer_cfg_t c);
    cnn_pkg::pix_t exp_q[$];
    cnn_pkg::pix_t got;
    int            fea;
    int            base;
    fea  = fea_of(c);
    base = int'(c.out_offset);
    for (int o = 0; o < int'(c.total_out); o++) begin
      for (int y = 0; y < fea; y++) begin
        for (int x = 0; x < fea; x++) begin
          exp_q.push_back(model_pixel(c, o, y, x));
        end
      end
    end
    // words just outside the output region stay as they were
    if (base > 0) begin
      host_read(base - 1, got);
      check_word("host_rdata", base - 1, got, img_sh[base - 1]);
    end
    host_read(base + exp_q.size(), got);
    check_word("host_rdata", base + exp_q.size(), got, img_sh[base + exp_q.size()]);
    for (int idx = 0; idx < exp_q.size(); idx++) begin
      host_read(base + idx, got);
      check_word("host_rdata", base + idx, got, exp_q[idx]);
      img_sh[base + idx] = exp_q[idx];
    end
  endtask

  // ==========================================================================
  // directed tests
  // ==========================================================================

  task automatic test_reset_and_access();
    cnn_pkg::pix_t got;
    int            err0;
    int            a;
    err0 = errors;
    check_bit("cmd_ready", cmd_ready, 1'b1);
    check_bit("done", done, 1'b0);
    for (int i = 0; i < IMG_DEPTH; i++) begin
      write_img(i, img_fill(i));
    end
    for (int i = 0; i < NET_DEPTH; i++) begin
      write_net(i, net_fill(i));
    end
    check_bit("cmd_ready", cmd_ready, 1'b1);
    for (int n = 0; n < 34; n++) begin
      a = (n == 0) ? 0 : (n == 1) ? IMG_DEPTH - 1 : rand_range(0, IMG_DEPTH - 1);
      host_read(a, got);
      check_word("host_rdata", a, got, img_sh[a]);
      check_bit("done", done, 1'b0);
    end
    end_test("reset and host access", err0);
  endtask

  task automatic test_unit_kernel();
    cnn_pkg::layer_cfg_t c;
    cnn_pkg::pix_t       got;
    int                  err0;
    err0 = errors;
    c = make_cfg(1, 1, 6, 1, 0, 64, 128, 16, 0, 0);
    for (int i = 0; i < 36; i++) begin
      write_img(64 + i, cnn_pkg::pix_t'(rand_range(-30000, 30000)));
    end
    write_net(16, 16'sd1);
    // bias word is set but must be ignored
    write_net(17, 16'sh7fff);
    run_layer(c);
    for (int i = 0; i < 36; i++) begin
      host_read(128 + i, got);
      check_word("host_rdata", 128 + i, got, img_sh[64 + i]);
      img_sh[128 + i] = img_sh[64 + i];
    end
    end_test("1x1 kernel copy", err0);
  endtask

  task automatic test_padded_multi();
    cnn_pkg::layer_cfg_t c;
    int                  err0;
    err0 = errors;
    c = make_cfg(2, 2, 5, 3, 1, 200, 300, 100, 1, 1);
    load_random_layer(c, -8, 7, -4, 3, -50, 50);
    run_layer(c);
    check_layer(c);
    end_test("3x3 padded, bias and relu", err0);
  endtask

  task automatic test_saturation();
    cnn_pkg::layer_cfg_t c;
    cnn_pkg::pix_t       got;
    int                  err0;
    int                  n_max;
    int                  n_min;
    int                  n_neg;
    err0  = errors;
    n_max = 0;
    n_min = 0;
    n_neg = 0;
    c = make_cfg(1, 2, 4, 2, 0, 400, 450, 200, 0, 0);
    // top rows large, bottom rows small of either sign
    for (int y = 0; y < 4; y++) begin
      for (int x = 0; x < 4; x++) begin
        write_img(400 + y * 4 + x, (y < 2) ? 16'sd20000 : (x < 2) ? -16'sd2 : 16'sd1);
      end
    end
    for (int j = 0; j < 4; j++) begin
      write_net(200 + j, 16'sd3000);
      write_net(205 + j, -16'sd3000);
    end
    write_net(204, 16'sd0);
    write_net(209, 16'sd0);
    run_layer(c);
    check_layer(c);
    for (int i = 0; i < 18; i++) begin
      host_read(450 + i, got);
      if (got == 16'sh7fff) n_max++;
      if (got == -16'sh8000) n_min++;
      if (got < 0 && got != -16'sh8000) n_neg++;
    end
    if (n_max == 0 || n_min == 0 || n_neg == 0) begin
      report_error("expected positive saturation, negative saturation and plain negatives");
    end
    end_test("relu off with saturation", err0);
  endtask

  task automatic test_held_command();
    cnn_pkg::layer_cfg_t cfg_a;
    cnn_pkg::layer_cfg_t cfg_b;
    cnn_pkg::pix_t       got;
    int                  err0;
    err0  = errors;
    cfg_a = make_cfg(2, 2, 6, 3, 0, 2000, 2200, 1200, 1, 0);
    cfg_b = make_cfg(1, 1, 5, 3, 1, 2400, 2500, 1300, 1, 1);
    load_random_layer(cfg_a, -20, 20, -8, 8, -100, 100);
    load_random_layer(cfg_b, -20, 20, -8, 8, -100, 100);
    send_cmd(cfg_a);
    cmd       = cfg_b;
    cmd_valid = 1'b1;
    // writes into the second layer's data while busy
    for (int j = 0; j < 4; j++) begin
      check_bit("cmd_ready", cmd_ready, 1'b0);
      drive_write(1'b0, 2400 + j, cnn_pkg::pix_t'(16'h7000 + j));
      drive_write(1'b1, 1300 + j, cnn_pkg::pix_t'(16'h7100 + j));
    end
    wait_done(layer_bound(cfg_a));
    check_bit("cmd_ready", cmd_ready, 1'b1);
    add_budget(1);
    @(posedge clk);
    #1;
    // held command goes in on the first idle edge
    check_bit("cmd_ready", cmd_ready, 1'b0);
    cmd_valid = 1'b0;
    wait_done(layer_bound(cfg_b));
    check_layer(cfg_a);
    check_layer(cfg_b);
    for (int j = 0; j < 4; j++) begin
      host_read(2400 + j, got);
      check_word("host_rdata", 2400 + j, got, img_sh[2400 + j]);
    end
    end_test("held command and busy writes", err0);
  endtask

  task automatic test_random_configs();
    cnn_pkg::layer_cfg_t c;
    int                  err0;
    int                  k;
    int                  pad;
    int                  img;
    err0 = errors;
    for (int r = 0; r < 3; r++) begin
      k   = rand_range(1, FSIZE);
      pad = rand_range(0, k - 1);
      img = rand_range(3, 7);
      if (img + 2 * pad < k) begin
        img = k;
      end
      c = make_cfg(rand_range(1, 3), rand_range(1, 3), img, k, pad, rand_range(1000, 1199),
                   rand_range(1500, 1699), rand_range(500, 699), rand_range(0, 1),
                   rand_range(0, 1));
      load_random_layer(c, -128, 127, -64, 63, -1000, 1000);
      run_layer(c);
      check_layer(c);
    end
    end_test("random configurations", err0);
  endtask

  initial begin
    void'($urandom(20));
    xrst      = 1'b0;
    cmd       = '0;
    cmd_valid = 1'b0;
    host_we   = 1'b0;
    host_wr   = '0;
    host_rd   = '0;
    repeat (3) @(posedge clk);
    #1;
    xrst = 1'b1;
    test_reset_and_access();
    test_unit_kernel();
    test_padded_multi();
    test_saturation();
    test_held_command();
    test_random_configs();
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
hw/cnn_pkg.sv
hw/sync_ram.sv
hw/conv_tap_sequencer.sv
hw/conv_pe.sv
hw/conv_ctrl_core.sv
hw/conv_layer_top.sv
verif/conv_layer_tb.sv
